//--- Bender.yml
package:
  name: bay_ctrl

sources:
  - verilog/bay_pkg.sv
  - verilog/heartbeat_gen.sv
  - verilog/bay_axil_regs.sv
  - verilog/bay_slot_monitor.sv
  - verilog/bay_ctrl_top.sv
  - target: simulation
    files:
      - dv/bay_ctrl_tb.sv

//--- compile.f
verilog/bay_pkg.sv
verilog/heartbeat_gen.sv
verilog/bay_axil_regs.sv
verilog/bay_slot_monitor.sv
verilog/bay_ctrl_top.sv
dv/bay_ctrl_tb.sv

//--- dv/bay_ctrl_tb.sv
/*
 * Drive bay controller testbench: clock and reset, AXI4-Lite
 * driver tasks, LFSR stimulus, reference model and comparing process
 */

`timescale 1ns/1ps
`default_nettype none

module bay_ctrl_tb;

	import bay_pkg::*;

	localparam int HB_HALF    = 16;
	localparam int WAIT_LIMIT = 64;

	logic       SYSCLK;
	logic       RESET_N;
	axil_addr_t s_awaddr;
	logic       s_awvalid;
	logic       s_awready;
	axil_data_t s_wdata;
	logic [3:0] s_wstrb;
	logic       s_wvalid;
	logic       s_wready;
	axil_resp_t s_bresp;
	logic       s_bvalid;
	logic       s_bready;
	axil_addr_t s_araddr;
	logic       s_arvalid;
	logic       s_arready;
	axil_data_t s_rdata;
	axil_resp_t s_rresp;
	logic       s_rvalid;
	logic       s_rready;
	bay_mask_t  drv_present;
	bay_mask_t  drv_pwr_ok;
	bay_mask_t  drv_pwr_en_l;
	logic       alert_l;
	logic       heartbeat;

	// Model of what the DUT should hold
	bay_mask_t   en_m;
	bay_mask_t   pres_m;
	bay_mask_t   pok_m;
	logic        alert_exp;
	logic [31:0] lfsr = 32'h2c6;

	// Checks waiting for the comparing process
	string       chk_name_q[$];
	logic [31:0] chk_got_q[$];
	logic [31:0] chk_exp_q[$];
	event        check_ev;

	bay_ctrl_top #(
		.HEARTBEAT_HALF_PERIOD (HB_HALF)
	) dut_i (.*);

	always
		#20 SYSCLK = !SYSCLK;

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	//**************************************************************************
	// Reference model
	//**************************************************************************
	function automatic axil_data_t read_model(input axil_addr_t addr);
		case (addr)
			REG_ID:      return 32'h5A31_0104;
			REG_PRESENT: return axil_data_t'(pres_m);
			REG_PWR_EN:  return axil_data_t'(en_m);
			REG_PWR_OK:  return axil_data_t'(pok_m);
			REG_ALERT:   return axil_data_t'(alert_exp);
			default:     return '0;
		endcase
	endfunction

	// Mapped offsets are the word-aligned ones from 0x00 to 0x10
	function automatic axil_resp_t resp_model(input axil_addr_t addr);
		return (addr <= REG_ALERT && addr[1:0] == 2'b00) ? RESP_OKAY : RESP_SLVERR;
	endfunction

	// A bay is powered only when enabled and present
	function automatic bay_mask_t pwr_en_l_model();
		bay_mask_t m;
		for (int b = 0; b < NUM_BAYS; b++)
			m[b] = !(en_m[b] && pres_m[b]);
		return m;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		chk_name_q.push_back(name);
		chk_got_q.push_back(got);
		chk_exp_q.push_back(exp);
		-> check_ev;
	endtask

	// Comparing process
	initial
	begin
		string       name;
		logic [31:0] got;
		logic [31:0] exp;
		forever
		begin
			@(check_ev);
			while (chk_name_q.size() > 0)
			begin
				name = chk_name_q.pop_front();
				got  = chk_got_q.pop_front();
				exp  = chk_exp_q.pop_front();
				assert (got === exp)
				else
				begin
					$display("MISMATCH at %0t ns: %s got %h expected %h",
						$time, name, got, exp);
					$display("test failed");
					$fatal(1, "stopped at first mismatch");
				end
			end
		end
	end

	//**************************************************************************
	// Driver tasks
	//**************************************************************************
	task automatic timeout_fail(input string what);
		$display("Timeout while waiting for %s", what);
		$display("test failed");
		$fatal(1, "wait limit reached");
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge SYSCLK);
	endtask

	task automatic write_check(input axil_addr_t addr, input axil_data_t data,
		input logic [3:0] strb);
		int   n;
		logic aw_rdy;
		logic w_rdy;
		@(negedge SYSCLK);
		s_awaddr  = addr;
		s_awvalid = 1'b1;
		s_wdata   = data;
		s_wstrb   = strb;
		s_wvalid  = 1'b1;
		s_bready  = 1'b1;
		// Readies as seen by the accepting edge
		n = 0;
		do
		begin
			@(posedge SYSCLK);
			aw_rdy = s_awready;
			w_rdy  = s_wready;
			n++;
			if (n > WAIT_LIMIT)
				timeout_fail("s_awready");
		end
		while (!aw_rdy);
		check_value("s_wready", w_rdy, 1'b1);
		@(negedge SYSCLK);
		check_value("s_bvalid", s_bvalid, 1'b1);
		check_value("s_awready", s_awready, 1'b0);
		check_value("s_wready", s_wready, 1'b0);
		check_value("s_bresp", s_bresp, resp_model(addr));
		s_awvalid = 1'b0;
		s_wvalid  = 1'b0;
	endtask

	// Read with optional back-pressure of hold cycles
	task automatic read_check(input axil_addr_t addr, input int hold);
		axil_data_t exp_data;
		axil_resp_t exp_resp;
		int         n;
		logic       ar_rdy;
		@(negedge SYSCLK);
		s_araddr  = addr;
		s_arvalid = 1'b1;
		s_rready  = (hold == 0);
		n = 0;
		do
		begin
			@(posedge SYSCLK);
			ar_rdy = s_arready;
			n++;
			if (n > WAIT_LIMIT)
				timeout_fail("s_arready");
		end
		while (!ar_rdy);
		@(negedge SYSCLK);
		exp_data = read_model(addr);
		exp_resp = resp_model(addr);
		check_value("s_rvalid", s_rvalid, 1'b1);
		check_value("s_arready", s_arready, 1'b0);
		check_value("s_rdata", s_rdata, exp_data);
		check_value("s_rresp", s_rresp, exp_resp);
		s_arvalid = 1'b0;
		repeat (hold)
		begin
			@(negedge SYSCLK);
			check_value("s_rvalid", s_rvalid, 1'b1);
			check_value("s_rdata", s_rdata, exp_data);
			check_value("s_rresp", s_rresp, exp_resp);
		end
		s_rready = 1'b1;
		// Accepted alert read releases the latch
		if (addr == REG_ALERT)
			alert_exp = 1'b0;
	endtask

	task automatic set_bays(input bay_mask_t present, input bay_mask_t pwr_ok);
		@(negedge SYSCLK);
		if (present != pres_m)
			alert_exp = 1'b1;
		pres_m      = present;
		pok_m       = pwr_ok;
		drv_present = present;
		drv_pwr_ok  = pwr_ok;
		wait_cycles(3);
	endtask

	//**************************************************************************
	// Test sequence
	//**************************************************************************
	initial
	begin
		int   cycles;
		int   idx;
		logic hb_last;
		SYSCLK      = 1'b0;
		RESET_N     = 1'b0;
		s_awaddr    = '0;
		s_awvalid   = 1'b0;
		s_wdata     = '0;
		s_wstrb     = '0;
		s_wvalid    = 1'b0;
		s_bready    = 1'b0;
		s_araddr    = '0;
		s_arvalid   = 1'b0;
		s_rready    = 1'b0;
		en_m        = '0;
		pok_m       = '0;
		pres_m      = bay_mask_t'(rand_bits(NUM_BAYS)) | 8'h01;
		alert_exp   = 1'b0;
		drv_present = pres_m;
		drv_pwr_ok  = pok_m;
		repeat (5) @(negedge SYSCLK);
		RESET_N = 1'b1;
		check_value("heartbeat", heartbeat, 1'b0);
		check_value("drv_pwr_en_l", drv_pwr_en_l, pwr_en_l_model());

		// Drives present at reset raise the alert
		alert_exp = 1'b1;
		wait_cycles(4);
		check_value("alert_l", alert_l, 1'b0);

		read_check(REG_ID, 0);
		write_check(REG_ID, rand_bits(32), 4'hF);
		read_check(REG_ID, 0);

		read_check(REG_ALERT, 0);
		check_value("alert_l", alert_l, 1'b1);
		read_check(REG_ALERT, 0);

		repeat (8)
		begin
			set_bays(bay_mask_t'(rand_bits(NUM_BAYS)), bay_mask_t'(rand_bits(NUM_BAYS)));
			read_check(REG_PRESENT, 0);
			read_check(REG_PWR_OK, 0);
			en_m = bay_mask_t'(rand_bits(NUM_BAYS));
			write_check(REG_PWR_EN, axil_data_t'(en_m), 4'h1);
			wait_cycles(1);
			check_value("drv_pwr_en_l", drv_pwr_en_l, pwr_en_l_model());
			read_check(REG_PWR_EN, 0);
			// Low byte differs but lane 0 is off
			write_check(REG_PWR_EN, (rand_bits(24) << 8) | axil_data_t'(~en_m), 4'hE);
			read_check(REG_PWR_EN, 0);
			read_check(REG_ALERT, 0);
		end

		// Single bay inserted or pulled
		idx = int'(rand_bits(3));
		@(negedge SYSCLK);
		pres_m[idx] = !pres_m[idx];
		drv_present = pres_m;
		alert_exp   = 1'b1;
		cycles      = 0;
		do
		begin
			@(negedge SYSCLK);
			cycles++;
		end
		while (alert_l !== 1'b0 && cycles < 4);
		check_value("alert_l", alert_l, 1'b0);
		read_check(REG_ALERT, 0);

		// Unmapped offset with the read held off for five cycles
		write_check(8'h14, rand_bits(32), 4'hF);
		read_check(8'h14, 5);
		read_check(REG_PWR_EN, 0);

		// Align on one heartbeat edge and time the next
		for (int k = 0; k < 2; k++)
		begin
			hb_last = heartbeat;
			cycles  = 0;
			do
			begin
				@(negedge SYSCLK);
				cycles++;
			end
			while (heartbeat == hb_last && cycles < WAIT_LIMIT);
		end
		check_value("heartbeat interval", cycles, HB_HALF);

		wait_cycles(1);
		if (chk_name_q.size() == 0)
		begin
			$display("test passed");
			$finish;
		end
		else
		begin
			$display("Checks were left without a comparison");
			$display("test failed");
			$fatal(1, "comparison queue not empty");
		end
	end

endmodule

`default_nettype wire

//--- verilog/bay_axil_regs.sv
/*
 * AXI4-Lite slave register file: address decode, power-enable
 * register, read word assembly, response codes and alert-clear strobe
 */

`timescale 1ns/1ps
`default_nettype none

module bay_axil_regs (
	input  wire                    SYSCLK,
	input  wire                    RESET_N,
	// Write address and data
	input  wire bay_pkg::axil_addr_t s_awaddr,
	input  wire                    s_awvalid,
	output logic                   s_awready,
	input  wire bay_pkg::axil_data_t s_wdata,
	input  wire [3:0]              s_wstrb,
	input  wire                    s_wvalid,
	output logic                   s_wready,
	// Write response
	output bay_pkg::axil_resp_t    s_bresp,
	output logic                   s_bvalid,
	input  wire                    s_bready,
	// Read address
	input  wire bay_pkg::axil_addr_t s_araddr,
	input  wire                    s_arvalid,
	output logic                   s_arready,
	// Read data
	output bay_pkg::axil_data_t    s_rdata,
	output bay_pkg::axil_resp_t    s_rresp,
	output logic                   s_rvalid,
	input  wire                    s_rready,
	// Slot monitor side
	input  wire bay_pkg::bay_mask_t present_sync,
	input  wire bay_pkg::bay_mask_t pwr_ok_sync,
	input  wire                    alert_pending,
	output bay_pkg::bay_mask_t     pwr_en,
	output logic                   alert_clear
);

	import bay_pkg::*;

	logic       wr_accept;
	logic       rd_accept;
	logic       wr_hit;
	logic       rd_hit;
	axil_data_t rd_word;

	//**************************************************************************
	// Handshakes
	//**************************************************************************

	// One transaction in flight per channel
	assign wr_accept = s_awvalid && s_wvalid && !s_bvalid;
	assign rd_accept = s_arvalid && !s_rvalid;

	assign s_awready = wr_accept;
	assign s_wready  = wr_accept;
	assign s_arready = rd_accept;

	// Reading the alert register releases the latch
	assign alert_clear = rd_accept && (s_araddr == REG_ALERT);

	//**************************************************************************
	// Address decode
	//**************************************************************************

	// All five offsets accept writes, only power enable stores anything
	always_comb
	begin
		case (s_awaddr)
			REG_ID, REG_PRESENT, REG_PWR_EN, REG_PWR_OK, REG_ALERT:
				wr_hit = 1'b1;
			default:
				wr_hit = 1'b0;
		endcase
	end

	// Read word mux, zero for unmapped offsets
	always_comb
	begin
		rd_hit  = 1'b1;
		rd_word = '0;
		case (s_araddr)
			REG_ID:      rd_word = {DEVICE_ID, FW_MAJOR, FW_MINOR};
			REG_PRESENT: rd_word = axil_data_t'(present_sync);
			REG_PWR_EN:  rd_word = axil_data_t'(pwr_en);
			REG_PWR_OK:  rd_word = axil_data_t'(pwr_ok_sync);
			REG_ALERT:   rd_word = axil_data_t'(alert_pending);
			default:     rd_hit  = 1'b0;
		endcase
	end

	//**************************************************************************
	// Write channel
	//**************************************************************************
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			s_bvalid <= 1'b0;
			pwr_en   <= '0;
		end
		else
		begin
			if (wr_accept)
				s_bvalid <= 1'b1;
			else if (s_bready)
				s_bvalid <= 1'b0;

			// Byte lane 0 carries all eight enables
			if (wr_accept && (s_awaddr == REG_PWR_EN) && s_wstrb[0])
				pwr_en <= s_wdata[NUM_BAYS-1:0];
		end
	end

	//**************************************************************************
	// Read channel
	//**************************************************************************
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
			s_rvalid <= 1'b0;
		else if (rd_accept)
			s_rvalid <= 1'b1;
		else if (s_rready)
			s_rvalid <= 1'b0;
	end

	// Response payload, held until the next acceptance
	always_ff @(posedge SYSCLK)
	begin
		if (wr_accept)
			s_bresp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
		if (rd_accept)
		begin
			s_rdata <= rd_word;
			s_rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
		end
	end

endmodule

`default_nettype wire

//--- verilog/bay_ctrl_top.sv
/*
 * Drive bay controller top level: register block,
 * slot monitor and heartbeat generator
 */

`timescale 1ns/1ps
`default_nettype none

module bay_ctrl_top #(
	parameter logic [31:0] HEARTBEAT_HALF_PERIOD = bay_pkg::HEARTBEAT_HALF_PERIOD
) (
	input  wire                      SYSCLK,
	input  wire                      RESET_N,
	// AXI4-Lite slave
	input  wire bay_pkg::axil_addr_t s_awaddr,
	input  wire                      s_awvalid,
	output wire                      s_awready,
	input  wire bay_pkg::axil_data_t s_wdata,
	input  wire [3:0]                s_wstrb,
	input  wire                      s_wvalid,
	output wire                      s_wready,
	output wire bay_pkg::axil_resp_t s_bresp,
	output wire                      s_bvalid,
	input  wire                      s_bready,
	input  wire bay_pkg::axil_addr_t s_araddr,
	input  wire                      s_arvalid,
	output wire                      s_arready,
	output wire bay_pkg::axil_data_t s_rdata,
	output wire bay_pkg::axil_resp_t s_rresp,
	output wire                      s_rvalid,
	input  wire                      s_rready,
	// Bay signals, asynchronous
	input  wire bay_pkg::bay_mask_t  drv_present,
	input  wire bay_pkg::bay_mask_t  drv_pwr_ok,
	output wire bay_pkg::bay_mask_t  drv_pwr_en_l,
	output wire                      alert_l,
	output wire                      heartbeat
);

	import bay_pkg::*;

	bay_mask_t pwr_en;
	bay_mask_t present_sync;
	bay_mask_t pwr_ok_sync;
	logic      alert_clear;
	logic      alert_pending;

	//**************************************************************************
	// Host register block
	//**************************************************************************
	bay_axil_regs regs_i (
		.SYSCLK        (SYSCLK),
		.RESET_N       (RESET_N),
		.s_awaddr      (s_awaddr),
		.s_awvalid     (s_awvalid),
		.s_awready     (s_awready),
		.s_wdata       (s_wdata),
		.s_wstrb       (s_wstrb),
		.s_wvalid      (s_wvalid),
		.s_wready      (s_wready),
		.s_bresp       (s_bresp),
		.s_bvalid      (s_bvalid),
		.s_bready      (s_bready),
		.s_araddr      (s_araddr),
		.s_arvalid     (s_arvalid),
		.s_arready     (s_arready),
		.s_rdata       (s_rdata),
		.s_rresp       (s_rresp),
		.s_rvalid      (s_rvalid),
		.s_rready      (s_rready),
		.present_sync  (present_sync),
		.pwr_ok_sync   (pwr_ok_sync),
		.alert_pending (alert_pending),
		.pwr_en        (pwr_en),
		.alert_clear   (alert_clear)
	);

	// Bay status and power gating
	bay_slot_monitor slot_mon_i (
		.SYSCLK        (SYSCLK),
		.RESET_N       (RESET_N),
		.drv_present   (drv_present),
		.drv_pwr_ok    (drv_pwr_ok),
		.pwr_en        (pwr_en),
		.alert_clear   (alert_clear),
		.present_sync  (present_sync),
		.pwr_ok_sync   (pwr_ok_sync),
		.drv_pwr_en_l  (drv_pwr_en_l),
		.alert_pending (alert_pending),
		.alert_l       (alert_l)
	);

	heartbeat_gen #(
		.HALF_PERIOD (HEARTBEAT_HALF_PERIOD)
	) heartbeat_i (
		.SYSCLK    (SYSCLK),
		.RESET_N   (RESET_N),
		.heartbeat (heartbeat)
	);

endmodule

`default_nettype wire

//--- verilog/bay_pkg.sv
/*
 * Shared definitions for the drive bay controller:
 * bay count and mask type, AXI4-Lite widths and response codes,
 * register offsets, identification constants, heartbeat interval
 */

`default_nettype none

package bay_pkg;

	//**************************************************************************
	// Bay bank
	//**************************************************************************
	localparam int NUM_BAYS = 8;

	// One bit per bay
	typedef logic [NUM_BAYS-1:0] bay_mask_t;

	//**************************************************************************
	// AXI4-Lite
	//**************************************************************************
	localparam int AXIL_ADDR_W = 8;
	localparam int AXIL_DATA_W = 32;

	typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
	typedef logic [AXIL_DATA_W-1:0] axil_data_t;
	typedef logic [1:0]             axil_resp_t;

	localparam axil_resp_t RESP_OKAY   = 2'd0;
	localparam axil_resp_t RESP_SLVERR = 2'd2;

	// Register byte offsets
	localparam axil_addr_t REG_ID      = 8'h00;
	localparam axil_addr_t REG_PRESENT = 8'h04;
	localparam axil_addr_t REG_PWR_EN  = 8'h08;
	localparam axil_addr_t REG_PWR_OK  = 8'h0C;
	localparam axil_addr_t REG_ALERT   = 8'h10;

	// Identification word fields
	localparam logic [15:0] DEVICE_ID = 16'h5A31;
	localparam logic [7:0]  FW_MAJOR  = 8'd1;
	localparam logic [7:0]  FW_MINOR  = 8'd4;

	// One second at 25 MHz
	localparam logic [31:0] HEARTBEAT_HALF_PERIOD = 32'd25_000_000;

endpackage

`default_nettype wire

//--- verilog/bay_slot_monitor.sv
/*
 * Bay status monitor: present and power-good synchronizers,
 * present change detect, alert latch, gated power enables
 */

`timescale 1ns/1ps
`default_nettype none

module bay_slot_monitor (
	input  wire                     SYSCLK,
	input  wire                     RESET_N,
	input  wire bay_pkg::bay_mask_t drv_present,
	input  wire bay_pkg::bay_mask_t drv_pwr_ok,
	input  wire bay_pkg::bay_mask_t pwr_en,
	input  wire                     alert_clear,
	output bay_pkg::bay_mask_t      present_sync,
	output bay_pkg::bay_mask_t      pwr_ok_sync,
	output bay_pkg::bay_mask_t      drv_pwr_en_l,
	output logic                    alert_pending,
	output logic                    alert_l
);

	import bay_pkg::*;

	bay_mask_t present_meta;
	bay_mask_t pwr_ok_meta;
	bay_mask_t present_dly;

	// Two-flop synchronizers plus delayed present copy
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			present_meta <= '0;
			present_sync <= '0;
			pwr_ok_meta  <= '0;
			pwr_ok_sync  <= '0;
			present_dly  <= '0;
		end
		else
		begin
			present_meta <= drv_present;
			present_sync <= present_meta;
			pwr_ok_meta  <= drv_pwr_ok;
			pwr_ok_sync  <= pwr_ok_meta;
			present_dly  <= present_sync;
		end
	end

	// Alert latch, host clear wins over a new change
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
			alert_pending <= 1'b0;
		else if (alert_clear)
			alert_pending <= 1'b0;
		else if (present_sync != present_dly)
			alert_pending <= 1'b1;
	end

	assign alert_l = !alert_pending;

	// Pulled drive loses power without waiting for the host
	assign drv_pwr_en_l = ~(pwr_en & present_sync);

endmodule

`default_nettype wire

//--- verilog/heartbeat_gen.sv
/*
 * Heartbeat output, toggled every HALF_PERIOD clocks
 */

`timescale 1ns/1ps
`default_nettype none

module heartbeat_gen #(
	parameter logic [31:0] HALF_PERIOD = bay_pkg::HEARTBEAT_HALF_PERIOD
) (
	input  wire  SYSCLK,
	input  wire  RESET_N,
	output logic heartbeat
);

	logic [31:0] cnt;

	// Counts 0 to HALF_PERIOD-1, toggles on wrap
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			cnt       <= '0;
			heartbeat <= 1'b0;
		end
		else if (cnt == HALF_PERIOD - 32'd1)
		begin
			cnt       <= '0;
			heartbeat <= !heartbeat;
		end
		else
			cnt <= cnt + 32'd1;
	end

endmodule

`default_nettype wire
